/* files.f */
source/wb_pkg.sv
source/wb_rr_arb.sv
source/wb_interconnect.sv
source/wb_stage.sv
source/wb_reg_slave.sv
source/wb_subsys_top.sv
tests/tb_wb_subsys.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_wb_subsys -f files.f -o sim_tb_wb_subsys

./obj_dir/sim_tb_wb_subsys | tee sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
  exit 0
else
  exit 1
fi

/* source/wb_interconnect.sv */
`timescale 1ns/100ps

module wb_interconnect import wb_pkg::*; #(
  parameter int NUM_MST = 3,
  parameter int NUM_SLV = 4,
  localparam int GNT_W = (NUM_MST > 1) ? $clog2(NUM_MST) : 1
) (
  input  logic    clk_i,
  input  logic    reset_i,

  // Master side
  input  wb_req_t m_req_i [NUM_MST],
  output wb_rsp_t m_rsp_o [NUM_MST],

  // Toward the staging stage
  output wb_req_t bus_req_o,
  input  wb_rsp_t bus_rsp_i
);

  // Requests with tid and hit filled in
  wb_req_t dec_req [NUM_MST];

  // Arbiter request lines
  logic [NUM_MST-1:0] req_vec;

  // Current owner of the bus
  logic [GNT_W-1:0] gnt;

  // --------------------
  // Address decode
  // --------------------

  // Region r maps to slave r when r is below NUM_SLV
  // Any other region is flagged unmapped and later errored by the stage
  always_comb begin
    logic [REGION_MSB-REGION_LSB:0] region;
    region = '0;
    for (int m = 0; m < NUM_MST; m++) begin
      region         = m_req_i[m].adr[REGION_MSB:REGION_LSB];
      dec_req[m]     = m_req_i[m];
      dec_req[m].hit = (region < NUM_SLV);
      dec_req[m].tid = dec_req[m].hit ? wb_tid_t'(region) : '0;
      // Classic cycle request needs both cyc and stb
      req_vec[m]     = m_req_i[m].cyc & m_req_i[m].stb;
    end
  end

  // --------------------
  // Arbitration
  // --------------------

  wb_rr_arb #(
    .NUM_MST (NUM_MST)
  ) wb_rr_arb_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (req_vec),
    .gnt_o   (gnt)
  );

  // Granted request goes to the stage
  // Other masters see their stb stalled
  always_comb begin
    bus_req_o = dec_req[0];
    for (int m = 1; m < NUM_MST; m++) begin
      if (gnt == GNT_W'(m)) begin
        bus_req_o = dec_req[m];
      end
    end
  end

  // --------------------
  // Response return
  // --------------------

  // Only the granted master sees the response, the rest get zero
  always_comb begin
    for (int m = 0; m < NUM_MST; m++) begin
      if (gnt == GNT_W'(m)) begin
        m_rsp_o[m] = bus_rsp_i;
      end else begin
        m_rsp_o[m] = '0;
      end
    end
  end

endmodule

/* source/wb_pkg.sv */
package wb_pkg;

  // --------------------
  // Bus geometry
  // --------------------

  // Data and address widths of the shared bus
  localparam int WB_DW = 32;
  localparam int WB_AW = 32;

  // One select per data byte
  localparam int WB_SW = WB_DW / 8;

  // Target id width, enough for four slaves
  localparam int TID_W = 2;

  // Address bits that pick the slave region
  localparam int REGION_MSB = 31;
  localparam int REGION_LSB = 28;

  // --------------------
  // Bus types
  // --------------------

  typedef logic [TID_W-1:0] wb_tid_t;

  // Request as seen by the interconnect and the slaves
  // tid and hit are filled in by the address decoder
  typedef struct packed {
    logic [WB_DW-1:0] dat;
    logic [WB_AW-1:0] adr;
    logic [WB_SW-1:0] sel;
    logic             we;
    logic             cyc;
    logic             stb;
    wb_tid_t          tid;
    logic             hit;
  } wb_req_t;

  // Response back toward a master
  typedef struct packed {
    logic [WB_DW-1:0] dat;
    logic             ack;
    logic             err;
  } wb_rsp_t;

  // Staging FSM states
  typedef enum logic [1:0] {
    STG_IDLE,
    STG_REQ,
    STG_RESP
  } stage_state_e;

endpackage

/* source/wb_reg_slave.sv */
`timescale 1ns/100ps

module wb_reg_slave import wb_pkg::*; #(
  parameter int SLV_WORDS = 16,
  localparam int IDX_W = (SLV_WORDS > 1) ? $clog2(SLV_WORDS) : 1,
  localparam int BO_W  = $clog2(WB_SW)
) (
  input  logic    clk_i,
  input  logic    reset_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  logic [WB_DW-1:0] regs_q [SLV_WORDS];

  // Word offset inside the slave region
  logic [REGION_LSB-BO_W-1:0] word_idx;
  logic [IDX_W-1:0]           widx;
  logic                       in_range;

  // New strobe, not yet answered
  logic new_req;

  logic             ack_q;
  logic             err_q;
  logic [WB_DW-1:0] rd_dat_q;

  assign word_idx = req_i.adr[REGION_LSB-1:BO_W];
  assign widx     = word_idx[IDX_W-1:0];
  assign in_range = (word_idx < SLV_WORDS);

  // Held stb is answered once, the pulse blocks a second hit
  assign new_req = req_i.cyc & req_i.stb & ~ack_q & ~err_q;

  // --------------------
  // Register bank
  // --------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      for (int i = 0; i < SLV_WORDS; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      ack_q <= new_req & in_range;
      // Out-of-range word, flag it and leave the bank untouched
      err_q <= new_req & ~in_range;
      if (new_req && in_range && req_i.we) begin
        for (int b = 0; b < WB_SW; b++) begin
          if (req_i.sel[b]) begin
            regs_q[widx][8*b +: 8] <= req_i.dat[8*b +: 8];
          end
        end
      end
    end
  end

  // Read data, lines up with the ack pulse
  always_ff @(posedge clk_i) begin
    if (new_req && in_range && !req_i.we) begin
      rd_dat_q <= regs_q[widx];
    end
  end

  assign rsp_o = '{dat: rd_dat_q, ack: ack_q, err: err_q};

endmodule

/* source/wb_rr_arb.sv */
`timescale 1ns/100ps

module wb_rr_arb #(
  parameter int NUM_MST = 3,
  localparam int GNT_W = (NUM_MST > 1) ? $clog2(NUM_MST) : 1
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic [NUM_MST-1:0] req_i,
  output logic [GNT_W-1:0]   gnt_o
);

  // Next holder of the grant
  logic [GNT_W-1:0] gnt_nxt;

  // --------------------
  // Rotation search
  // --------------------

  // Grant is kept while the holder still requests
  // Otherwise look at the masters after the holder, nearest one wins
  always_comb begin
    int unsigned idx;
    gnt_nxt = gnt_o;
    idx     = 0;
    if (!req_i[gnt_o]) begin
      // Walk from the farthest to the nearest so the nearest is set last
      for (int k = NUM_MST - 1; k >= 1; k--) begin
        idx = (int'(gnt_o) + k) % NUM_MST;
        if (req_i[idx]) begin
          gnt_nxt = idx[GNT_W-1:0];
        end
      end
    end
  end

  // --------------------
  // Grant register
  // --------------------

  // Master 0 owns the bus after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gnt_o <= '0;
    end else begin
      gnt_o <= gnt_nxt;
    end
  end

endmodule

/* source/wb_stage.sv */
`timescale 1ns/100ps

module wb_stage import wb_pkg::*; #(
  parameter int NUM_SLV = 4
) (
  input  logic    clk_i,
  input  logic    reset_i,

  // Arbitrated bus
  input  wb_req_t bus_req_i,
  output wb_rsp_t bus_rsp_o,

  // Slave side
  output wb_req_t slv_req_o [NUM_SLV],
  input  wb_rsp_t slv_rsp_i [NUM_SLV]
);

  stage_state_e state_q;

  // Captured request, held stable while the slave works
  wb_req_t req_q;

  // Registered response
  logic [WB_DW-1:0] rsp_dat_q;
  logic             rsp_ack_q;
  logic             rsp_err_q;

  // Local error for unmapped regions, delayed to match slave timing
  logic unm_err_q;

  // Response picked for the captured target
  wb_rsp_t sel_rsp;
  logic    rsp_done;

  // --------------------
  // Request steering
  // --------------------

  // Only the addressed slave sees cyc and stb, and only in STG_REQ
  always_comb begin
    for (int s = 0; s < NUM_SLV; s++) begin
      slv_req_o[s] = '0;
      if (state_q == STG_REQ && req_q.hit && req_q.tid == wb_tid_t'(s)) begin
        slv_req_o[s] = req_q;
      end
    end
  end

  // Unmapped requests answer with err from the stage
  always_comb begin
    sel_rsp = '0;
    if (req_q.hit) begin
      sel_rsp = slv_rsp_i[req_q.tid];
    end else begin
      sel_rsp.err = unm_err_q;
    end
  end

  assign rsp_done = sel_rsp.ack | sel_rsp.err;

  // --------------------
  // Control FSM
  // --------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= STG_IDLE;
      rsp_ack_q <= 1'b0;
      rsp_err_q <= 1'b0;
      unm_err_q <= 1'b0;
    end else begin
      // Ack and err are single-cycle pulses
      rsp_ack_q <= 1'b0;
      rsp_err_q <= 1'b0;
      unm_err_q <= 1'b0;
      case (state_q)
        STG_IDLE: begin
          if (bus_req_i.cyc && bus_req_i.stb) begin
            state_q <= STG_REQ;
          end
        end
        STG_REQ: begin
          // One cycle of latency, same as a slave
          unm_err_q <= ~req_q.hit & ~unm_err_q;
          if (rsp_done) begin
            rsp_ack_q <= sel_rsp.ack;
            rsp_err_q <= sel_rsp.err;
            state_q   <= STG_RESP;
          end
        end
        STG_RESP: state_q <= STG_IDLE;
        default:  state_q <= STG_IDLE;
      endcase
    end
  end

  // Payload capture, no reset needed
  always_ff @(posedge clk_i) begin
    if (state_q == STG_IDLE && bus_req_i.cyc && bus_req_i.stb) begin
      req_q <= bus_req_i;
    end
    if (state_q == STG_REQ && rsp_done) begin
      rsp_dat_q <= sel_rsp.dat;
    end
  end

  assign bus_rsp_o = '{dat: rsp_dat_q, ack: rsp_ack_q, err: rsp_err_q};

endmodule

/* source/wb_subsys_top.sv */
`timescale 1ns/100ps

module wb_subsys_top import wb_pkg::*; #(
  parameter int NUM_MST   = 3,
  parameter int NUM_SLV   = 4,
  parameter int SLV_WORDS = 16
) (
  input  logic    clk_i,
  input  logic    reset_i,
  input  wb_req_t m_req_i [NUM_MST],
  output wb_rsp_t m_rsp_o [NUM_MST]
);

  // Arbitrated bus between interconnect and stage
  wb_req_t bus_req;
  wb_rsp_t bus_rsp;

  // Per-slave request and response
  wb_req_t slv_req [NUM_SLV];
  wb_rsp_t slv_rsp [NUM_SLV];

  // --------------------
  // Master side
  // --------------------

  wb_interconnect #(
    .NUM_MST (NUM_MST),
    .NUM_SLV (NUM_SLV)
  ) wb_interconnect_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .m_req_i   (m_req_i),
    .m_rsp_o   (m_rsp_o),
    .bus_req_o (bus_req),
    .bus_rsp_i (bus_rsp)
  );

  // Staging registers break the path to the slaves
  wb_stage #(
    .NUM_SLV (NUM_SLV)
  ) wb_stage_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .slv_req_o (slv_req),
    .slv_rsp_i (slv_rsp)
  );

  // --------------------
  // Slave banks
  // --------------------

  for (genvar s = 0; s < NUM_SLV; s++) begin : g_slv
    wb_reg_slave #(
      .SLV_WORDS (SLV_WORDS)
    ) wb_reg_slave_inst (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (slv_req[s]),
      .rsp_o   (slv_rsp[s])
    );
  end

endmodule

/* tests/tb_wb_subsys.sv */
`timescale 1ns/100ps

module tb_wb_subsys
  import wb_pkg::*;
();

  localparam int NUM_MST   = 3;
  localparam int NUM_SLV   = 4;
  localparam int SLV_WORDS = 16;
  // Whole run is a few hundred cycles
  // Limit sits far above that
  localparam int MAX_CYCLES = 4000;
  localparam int RUN_LEN    = 6;

  logic    clk;
  logic    reset;
  wb_req_t m_req [NUM_MST];
  wb_rsp_t m_rsp [NUM_MST];

  // Reference copy of every slave register
  logic [WB_DW-1:0] ref_mem [NUM_SLV][SLV_WORDS];

  // Masters in the order their cycles ended
  int ack_order [$];

  int seed      = 43;
  int err_cnt   = 0;
  int test_err  = 0;
  int tests_ok  = 0;
  int tests_bad = 0;
  int cycle_cnt = 0;

  wb_subsys_top #(
    .NUM_MST   (NUM_MST),
    .NUM_SLV   (NUM_SLV),
    .SLV_WORDS (SLV_WORDS)
  ) wb_subsys_top_inst (
    .clk_i   (clk),
    .reset_i (reset),
    .m_req_i (m_req),
    .m_rsp_o (m_rsp)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // --------------------
  // Protocol checks
  // --------------------

  for (genvar g = 0; g < NUM_MST; g++) begin : g_proto
    // A response only ever lands on a master that is strobing
    rsp_needs_stb: assert property (@(posedge clk) disable iff (reset)
        (m_rsp[g].ack || m_rsp[g].err) |-> m_req[g].stb)
      else begin
        $display("master %0d saw ack or err while its stb was low", g);
        err_cnt++;
      end
    // Never both at once
    ack_err_excl: assert property (@(posedge clk) disable iff (reset)
        !(m_rsp[g].ack && m_rsp[g].err))
      else begin
        $display("master %0d saw ack and err in the same cycle", g);
        err_cnt++;
      end
  end

  task automatic check_hex(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp)
      else begin
        $display("error %s expected %h got %h", name, exp, got);
        err_cnt++;
      end
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_err) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, err_cnt - test_err);
    end
    test_err = err_cnt;
  endtask

  // Region in the top nibble and word index above the byte offset
  function automatic logic [WB_AW-1:0] make_adr(input int s, input int w);
    return (32'(s) << 28) | (32'(w) << 2);
  endfunction

  // Byte-select write rule of the register banks
  function automatic logic [WB_DW-1:0] merge_bytes(input logic [WB_DW-1:0] old,
                                                   input logic [WB_DW-1:0] dat,
                                                   input logic [WB_SW-1:0] sel);
    logic [WB_DW-1:0] res;
    res = old;
    for (int b = 0; b < WB_SW; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = dat[8*b +: 8];
      end
    end
    return res;
  endfunction

  // --------------------
  // Master driver
  // --------------------

  task automatic bus_cycle(input int m, input logic [WB_AW-1:0] adr, input logic we,
                           input logic [WB_SW-1:0] sel, input logic [WB_DW-1:0] wdat,
                           output logic [WB_DW-1:0] rdat, output logic ack,
                           output logic err, output int lat);
    lat = 0;
    @(posedge clk);
    #1;
    m_req[m].adr = adr;
    m_req[m].dat = wdat;
    m_req[m].sel = sel;
    m_req[m].we  = we;
    m_req[m].cyc = 1'b1;
    m_req[m].stb = 1'b1;
    // Mid-cycle value is what the next rising edge takes
    @(negedge clk);
    while (!(m_rsp[m].ack || m_rsp[m].err)) begin
      lat++;
      @(negedge clk);
    end
    rdat = m_rsp[m].dat;
    ack  = m_rsp[m].ack;
    err  = m_rsp[m].err;
    ack_order.push_back(m);
    // Drop cyc and stb in the cycle after the response edge
    @(posedge clk);
    #1;
    m_req[m] = '0;
  endtask

  // One access checked against the memory map and the model
  task automatic checked_access(input int m, input logic [WB_AW-1:0] adr, input logic we,
                                input logic [WB_SW-1:0] sel, input logic [WB_DW-1:0] wdat,
                                input bit timed);
    logic [WB_DW-1:0] rdat;
    logic             ack;
    logic             err;
    int               lat;
    int               s;
    int               w;
    bit               mapped;
    s      = int'(adr[31:28]);
    w      = int'(adr[27:2]);
    mapped = (s < NUM_SLV) && (w < SLV_WORDS);
    bus_cycle(m, adr, we, sel, wdat, rdat, ack, err, lat);
    check_hex($sformatf("m_rsp_o[%0d].ack", m), 32'(mapped), 32'(ack));
    check_hex($sformatf("m_rsp_o[%0d].err", m), 32'(!mapped), 32'(err));
    if (timed) begin
      check_hex($sformatf("m_rsp_o[%0d] latency", m), 32'd3, 32'(lat));
    end
    if (mapped && we) begin
      ref_mem[s][w] = merge_bytes(ref_mem[s][w], wdat, sel);
    end else if (mapped) begin
      check_hex($sformatf("m_rsp_o[%0d].dat", m), ref_mem[s][w], rdat);
    end
  endtask

  // Write then read back a word owned by this master only
  task automatic master_run(input int m);
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] dat;
    for (int i = 0; i < RUN_LEN; i++) begin
      adr = make_adr((i / 2) % NUM_SLV, 4 + m);
      dat = 32'hC0DE_0000 | 32'(m << 8) | 32'(i);
      checked_access(m, adr, (i % 2 == 0), 4'hF, dat, 1'b0);
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    logic [WB_DW-1:0] rnd;
    logic [WB_DW-1:0] dat;
    reset = 1'b1;
    for (int m = 0; m < NUM_MST; m++) begin
      m_req[m] = '0;
    end
    for (int s = 0; s < NUM_SLV; s++) begin
      for (int w = 0; w < SLV_WORDS; w++) begin
        ref_mem[s][w] = '0;
      end
    end
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    // Idle bus shows no response
    repeat (4) begin
      @(negedge clk);
      for (int m = 0; m < NUM_MST; m++) begin
        check_hex($sformatf("m_rsp_o[%0d].ack", m), 32'd0, 32'(m_rsp[m].ack));
        check_hex($sformatf("m_rsp_o[%0d].err", m), 32'd0, 32'(m_rsp[m].err));
      end
    end
    end_test("1 quiet after reset");

    // Full words to every slave from master 0 alone
    for (int s = 0; s < NUM_SLV; s++) begin
      for (int w = 0; w < 4; w++) begin
        rnd = $random(seed);
        checked_access(0, make_adr(s, w), 1'b1, 4'hF, rnd, 1'b1);
        checked_access(0, make_adr(s, w), 1'b0, 4'h0, '0, 1'b1);
      end
    end
    end_test("2 full word write and read");

    // Mixed byte selects
    repeat (12) begin
      rnd = $random(seed);
      dat = $random(seed);
      checked_access(0, make_adr(int'(rnd[5:4]) % NUM_SLV, int'(rnd[3:0])), 1'b1,
                     rnd[11:8], dat, 1'b1);
      checked_access(0, make_adr(int'(rnd[5:4]) % NUM_SLV, int'(rnd[3:0])), 1'b0,
                     4'h0, '0, 1'b1);
    end
    end_test("3 byte select merge");

    // Word 16 of slave 1 and unmapped region 5 followed by reads of the aliased words
    checked_access(0, 32'h1000_0040, 1'b1, 4'hF, 32'hDEAD_BEEF, 1'b1);
    checked_access(0, 32'h1000_0000, 1'b0, 4'h0, '0, 1'b1);
    checked_access(0, 32'h5000_0004, 1'b1, 4'hF, 32'hDEAD_BEEF, 1'b1);
    checked_access(0, 32'h1000_0004, 1'b0, 4'h0, '0, 1'b1);
    checked_access(0, 32'hF000_0000, 1'b0, 4'h0, '0, 1'b1);
    checked_access(0, 32'h2000_0044, 1'b0, 4'h0, '0, 1'b1);
    end_test("4 error responses");

    // All masters contend with the grant starting on master 0
    ack_order.delete();
    fork
      master_run(0);
      master_run(1);
      master_run(2);
    join
    for (int i = 0; i < ack_order.size(); i++) begin
      check_hex($sformatf("ack_order[%0d]", i), 32'(i % NUM_MST), 32'(ack_order[i]));
    end
    end_test("5 round robin contention");

    $display("tests ok %0d, tests with errors %0d, error count %0d",
             tests_ok, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
